// File: rtl/noc_router_pkg.sv
////////////////////////////////////////
// Shared widths, flit layout, port and direction encodings for the router
// Imported by every RTL block of the mesh router
////////////////////////////////////////
package noc_router_pkg;

  ////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////

  // Flit body without the head/tail preamble
  localparam int DataWidth = 32;
  localparam int PortWidth = DataWidth + 2;

  // Preamble bit positions
  localparam int HeadBit = PortWidth - 1;
  localparam int TailBit = PortWidth - 2;

  typedef logic [PortWidth-1:0] flit_t;

  // Mesh position, x in the upper half
  typedef logic [2:0] coord_t;
  typedef logic [5:0] xy_t;

  // Head flit fields
  localparam int DestLsb    = 26;
  localparam int SrcLsb     = 20;
  localparam int RouteLsb   = 0;
  localparam int RouteWidth = 5;

  ////////////////////////////////////////
  // Ports and directions
  ////////////////////////////////////////

  // One-hot routing direction, bit position equals the port index
  typedef logic [RouteWidth-1:0] dir_t;

  localparam dir_t GoNorth = 5'b00001;
  localparam dir_t GoSouth = 5'b00010;
  localparam dir_t GoWest  = 5'b00100;
  localparam dir_t GoEast  = 5'b01000;
  localparam dir_t GoLocal = 5'b10000;

  typedef enum logic [2:0] {
    PortNorth = 3'd0,
    PortSouth = 3'd1,
    PortWest  = 3'd2,
    PortEast  = 3'd3,
    PortLocal = 3'd4
  } port_e;

  localparam int NumPorts = 5;

  // Input queue sizing
  localparam int QueueDepth = 4;
  typedef logic [$clog2(QueueDepth)-1:0] queue_ptr_t;

  ////////////////////////////////////////
  // XY helpers
  ////////////////////////////////////////

  // Neighbor position one hop away, north is y minus one
  function automatic xy_t step_xy(xy_t pos, dir_t dir);
    coord_t x;
    coord_t y;
    x = pos[5:3];
    y = pos[2:0];
    case (dir)
      GoNorth: y = y - 3'd1;
      GoSouth: y = y + 3'd1;
      GoWest:  x = x - 3'd1;
      GoEast:  x = x + 3'd1;
      default: ;
    endcase
    return {x, y};
  endfunction

endpackage

// File: rtl/router_input_queue.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Input queue of one router port, bypassed when empty
// Presents the head-of-line flit and the routing request of its worm
////////////////////////////////////////
module router_input_queue (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_router_pkg::flit_t wr_flit_i,
  input  logic                  wr_valid_i,
  input  logic                  rd_i,
  output noc_router_pkg::flit_t head_flit_o,
  output logic                  head_valid_o,
  output noc_router_pkg::dir_t  route_req_o,
  output logic                  full_o
);
  import noc_router_pkg::*;

  // Flit storage
  flit_t      mem_q [QueueDepth];
  queue_ptr_t wr_ptr_q;
  queue_ptr_t rd_ptr_q;
  logic       full_q;
  logic       empty_q;
  logic       push;
  logic       pop;
  logic       head_present;
  dir_t       saved_req_q;

  // Empty queue shows the incoming flit directly
  assign head_flit_o  = empty_q ? wr_flit_i : mem_q[rd_ptr_q];
  assign head_valid_o = empty_q ? wr_valid_i : 1'b1;
  assign full_o       = full_q;

  // A bypassed flit read in the same cycle never enters the buffer
  assign push = wr_valid_i & ~full_q & ~(empty_q & rd_i);
  assign pop  = rd_i & ~empty_q;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_flit_i;
    end
  end

  ////////////////////////////////////////
  // Pointers and registered flags
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Flags only move when occupancy changes
      if (push && !pop) begin
        empty_q <= 1'b0;
        full_q  <= (queue_ptr_t'(wr_ptr_q + 1'b1) == rd_ptr_q);
      end else if (pop && !push) begin
        full_q  <= 1'b0;
        empty_q <= (queue_ptr_t'(rd_ptr_q + 1'b1) == wr_ptr_q);
      end
    end
  end

  ////////////////////////////////////////
  // Routing request of the current worm
  ////////////////////////////////////////
  assign head_present = head_valid_o & head_flit_o[HeadBit];
  assign route_req_o  = head_present ? head_flit_o[RouteLsb +: RouteWidth] : saved_req_q;

  // Kept for body flits, dropped once the tail is read
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_req_q <= '0;
    end else if (rd_i && head_valid_o && head_flit_o[TailBit]) begin
      saved_req_q <= '0;
    end else if (head_present) begin
      saved_req_q <= head_flit_o[RouteLsb +: RouteWidth];
    end
  end

endmodule

// File: rtl/router_rr_arbiter.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Round-robin arbiter for one output port
////////////////////////////////////////
module router_rr_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [4:0] req_i,
  input  logic       tail_done_i,
  output logic [4:0] grant_o,
  output logic       grant_valid_o
);
  import noc_router_pkg::*;

  // Last winner, the input after it has top priority
  logic [2:0] last_q;
  logic [2:0] win_idx;
  logic       found;

  // Scan the inputs starting just past the last winner
  always_comb begin
    logic [3:0] idx;
    grant_o = '0;
    win_idx = last_q;
    found   = 1'b0;
    for (int k = 1; k <= NumPorts; k++) begin
      idx = {1'b0, last_q} + 4'(k);
      // Wrap around the five inputs
      if (idx >= 4'(NumPorts)) begin
        idx = idx - 4'(NumPorts);
      end
      if (req_i[idx[2:0]] && !found) begin
        grant_o[idx[2:0]] = 1'b1;
        win_idx           = idx[2:0];
        found             = 1'b1;
      end
    end
  end

  assign grant_valid_o = |req_i;

  // Priority moves only when a worm has fully left
  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= 3'(NumPorts - 1);
    end else if (tail_done_i) begin
      last_q <= win_idx;
    end
  end

endmodule

// File: rtl/lookahead_xy_route.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Lookahead XY routing for the next router on the path
////////////////////////////////////////
module lookahead_xy_route (
  input  noc_router_pkg::xy_t  position_i,
  input  noc_router_pkg::dir_t out_dir_i,
  input  noc_router_pkg::xy_t  dest_i,
  output noc_router_pkg::dir_t next_dir_o
);
  import noc_router_pkg::*;

  xy_t    neighbor;
  coord_t nb_x;
  coord_t nb_y;
  coord_t dst_x;
  coord_t dst_y;

  // Position of the router this flit will enter
  assign neighbor = step_xy(position_i, out_dir_i);
  assign nb_x     = neighbor[5:3];
  assign nb_y     = neighbor[2:0];
  assign dst_x    = dest_i[5:3];
  assign dst_y    = dest_i[2:0];

  // X first, then Y, then eject
  always_comb begin
    if (out_dir_i == GoLocal) begin
      // Leaving the mesh, the field is no longer used
      next_dir_o = GoLocal;
    end else if (dst_x > nb_x) begin
      next_dir_o = GoEast;
    end else if (dst_x < nb_x) begin
      next_dir_o = GoWest;
    end else if (dst_y > nb_y) begin
      next_dir_o = GoSouth;
    end else if (dst_y < nb_y) begin
      next_dir_o = GoNorth;
    end else begin
      next_dir_o = GoLocal;
    end
  end

endmodule

// File: rtl/router_output_port.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Output port: worm FSM, crossbar leg, lookahead insert and output register
// One instance per direction, PortIdx selects which one
////////////////////////////////////////
module router_output_port #(
  parameter noc_router_pkg::port_e PortIdx = noc_router_pkg::PortNorth
) (
  input  logic                        clk,
  input  logic                        rst,
  input  noc_router_pkg::xy_t         position_i,
  input  noc_router_pkg::flit_t [4:0] head_flits_i,
  input  logic                  [4:0] head_valid_i,
  input  noc_router_pkg::dir_t  [4:0] route_req_i,
  input  logic                        stop_i,
  output logic                  [4:0] rd_sel_o,
  output noc_router_pkg::flit_t       data_o,
  output logic                        data_void_o
);
  import noc_router_pkg::*;

  typedef enum logic {
    WaitHead,
    ForwardBody
  } worm_state_e;

  // Direction this port drives
  localparam dir_t OwnDir = dir_t'(1 << PortIdx);

  worm_state_e state_q;
  logic [4:0]  sel_q;
  logic [4:0]  head_req;
  logic [4:0]  arb_req;
  logic [4:0]  grant;
  logic [4:0]  sel;
  logic        grant_valid;
  logic        sel_valid;
  logic        fwd;
  logic        tail_done;
  flit_t       sel_flit;
  flit_t       out_flit;
  dir_t        next_dir;

  // Valid heads of other inputs routed here, own input masked
  always_comb begin
    for (int j = 0; j < NumPorts; j++) begin
      head_req[j] = head_valid_i[j] & head_flits_i[j][HeadBit] &
                    route_req_i[j][PortIdx] & (j != int'(PortIdx));
    end
  end

  // While a worm is in flight only its input competes
  assign arb_req = (state_q == WaitHead) ? head_req : sel_q;
  assign sel     = (state_q == WaitHead) ? (grant & {5{grant_valid}}) : sel_q;

  router_rr_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .req_i        (arb_req),
    .tail_done_i  (tail_done),
    .grant_o      (grant),
    .grant_valid_o(grant_valid)
  );

  ////////////////////////////////////////
  // Crossbar leg
  ////////////////////////////////////////
  always_comb begin
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int j = 0; j < NumPorts; j++) begin
      if (sel[j]) begin
        sel_flit  = head_flits_i[j];
        sel_valid = head_valid_i[j];
      end
    end
  end

  // Read only when downstream can take the flit
  assign fwd       = sel_valid & ~stop_i;
  assign rd_sel_o  = sel & head_valid_i & {5{~stop_i}};
  assign tail_done = fwd & sel_flit[TailBit];

  lookahead_xy_route u_route (
    .position_i(position_i),
    .out_dir_i (OwnDir),
    .dest_i    (sel_flit[DestLsb +: $bits(xy_t)]),
    .next_dir_o(next_dir)
  );

  // Head flit carries the next router's direction
  always_comb begin
    out_flit = sel_flit;
    if (state_q == WaitHead) begin
      out_flit[RouteLsb +: RouteWidth] = next_dir;
    end
  end

  ////////////////////////////////////////
  // Worm FSM
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= WaitHead;
      sel_q   <= '0;
    end else begin
      case (state_q)
        WaitHead: begin
          // Single-flit packets never leave WaitHead
          if (fwd && !sel_flit[TailBit]) begin
            state_q <= ForwardBody;
            sel_q   <= sel;
          end
        end
        ForwardBody: begin
          if (tail_done) begin
            state_q <= WaitHead;
            sel_q   <= '0;
          end
        end
        default: state_q <= WaitHead;
      endcase
    end
  end

  // Output register, frozen while stopped
  always_ff @(posedge clk) begin
    if (!stop_i) begin
      data_o <= out_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_void_o <= 1'b1;
    end else if (!stop_i) begin
      data_void_o <= ~fwd;
    end
  end

endmodule

// File: rtl/mesh_router.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Five-port mesh router top, wormhole switching with void/stop links
// position_i is the static XY location of this router
////////////////////////////////////////
module mesh_router (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_router_pkg::xy_t   position_i,
  // Incoming links
  input  noc_router_pkg::flit_t data_n_i,
  input  noc_router_pkg::flit_t data_s_i,
  input  noc_router_pkg::flit_t data_w_i,
  input  noc_router_pkg::flit_t data_e_i,
  input  noc_router_pkg::flit_t data_p_i,
  input  logic [4:0]            data_void_i,
  output logic [4:0]            stop_o,
  // Outgoing links
  output noc_router_pkg::flit_t data_n_o,
  output noc_router_pkg::flit_t data_s_o,
  output noc_router_pkg::flit_t data_w_o,
  output noc_router_pkg::flit_t data_e_o,
  output noc_router_pkg::flit_t data_p_o,
  output logic [4:0]            data_void_o,
  input  logic [4:0]            stop_i
);
  import noc_router_pkg::*;

  flit_t [NumPorts-1:0] in_flit;
  flit_t [NumPorts-1:0] out_flit;
  flit_t [NumPorts-1:0] head_flit;
  logic  [NumPorts-1:0] head_valid;
  dir_t  [NumPorts-1:0] route_req;
  // Read vector of each output, one bit per input
  logic  [NumPorts-1:0] rd_sel [NumPorts];
  logic  [NumPorts-1:0] rd;

  assign in_flit[PortNorth] = data_n_i;
  assign in_flit[PortSouth] = data_s_i;
  assign in_flit[PortWest]  = data_w_i;
  assign in_flit[PortEast]  = data_e_i;
  assign in_flit[PortLocal] = data_p_i;

  assign data_n_o = out_flit[PortNorth];
  assign data_s_o = out_flit[PortSouth];
  assign data_w_o = out_flit[PortWest];
  assign data_e_o = out_flit[PortEast];
  assign data_p_o = out_flit[PortLocal];

  // Queue read strobe is the OR over all outputs
  always_comb begin
    rd = '0;
    for (int o = 0; o < NumPorts; o++) begin
      rd = rd | rd_sel[o];
    end
  end

  ////////////////////////////////////////
  // Input side, full queue raises stop
  ////////////////////////////////////////
  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    router_input_queue u_queue (
      .clk         (clk),
      .rst         (rst),
      .wr_flit_i   (in_flit[i]),
      .wr_valid_i  (~data_void_i[i]),
      .rd_i        (rd[i]),
      .head_flit_o (head_flit[i]),
      .head_valid_o(head_valid[i]),
      .route_req_o (route_req[i]),
      .full_o      (stop_o[i])
    );
  end

  // Output side
  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    router_output_port #(
      .PortIdx(port_e'(o))
    ) u_port (
      .clk         (clk),
      .rst         (rst),
      .position_i  (position_i),
      .head_flits_i(head_flit),
      .head_valid_i(head_valid),
      .route_req_i (route_req),
      .stop_i      (stop_i[o]),
      .rd_sel_o    (rd_sel[o]),
      .data_o      (out_flit[o]),
      .data_void_o (data_void_o[o])
    );
  end

endmodule

// File: dv/mesh_router_properties.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Link protocol checks bound into the router top
////////////////////////////////////////
module mesh_router_properties (
  input logic                                 clk,
  input logic                                 rst,
  input logic [24:0]                          rd_sel_i,
  input logic [4:0]                           stop_i,
  input logic [4:0]                           data_void_i,
  input logic [5*noc_router_pkg::PortWidth-1:0] data_i
);
  import noc_router_pkg::*;

  // Set while an output is inside a worm
  logic [NumPorts-1:0] worm_open_q;

  // Number of failed assertions
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      worm_open_q <= '0;
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (!data_void_i[o] && !stop_i[o]) begin
          worm_open_q[o] <= ~data_i[o*PortWidth + TailBit];
        end
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_check
    flit_t flit;
    assign flit = data_i[o*PortWidth +: PortWidth];

    // One input read per output at most
    assert property (@(posedge clk) disable iff (rst) $onehot0(rd_sel_i[5*o +: 5]))
      else begin
        $error("output %0d reads more than one input", o);
        fail_count++;
      end

    // Output register frozen under stop
    assert property (@(posedge clk) disable iff (rst)
                     stop_i[o] |=> ($stable(flit) && $stable(data_void_i[o])))
      else begin
        $error("output %0d changed while stopped", o);
        fail_count++;
      end

    assert property (@(posedge clk) disable iff (rst)
                     (!data_void_i[o] && !worm_open_q[o]) |-> flit[HeadBit])
      else begin
        $error("output %0d started a worm without a head flit", o);
        fail_count++;
      end
  end

endmodule

bind mesh_router mesh_router_properties u_props (
  .clk        (clk),
  .rst        (rst),
  .rd_sel_i   ({rd_sel[4], rd_sel[3], rd_sel[2], rd_sel[1], rd_sel[0]}),
  .stop_i     (stop_i),
  .data_void_i(data_void_o),
  .data_i     ({data_p_o, data_e_o, data_w_o, data_s_o, data_n_o})
);

// File: dv/mesh_router_tb.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Directed testbench for the five-port mesh router at position (2,2)
// Drives worms on the input links and checks the flits taken on each output
////////////////////////////////////////
module mesh_router_tb;
  import noc_router_pkg::*;

  localparam int WaitLimit = 200;
  // Router position under test
  localparam int MyX = 2;
  localparam int MyY = 2;

  logic       clk;
  logic       rst;
  xy_t        position;
  flit_t      data_n_i, data_s_i, data_w_i, data_e_i, data_p_i;
  flit_t      data_n_o, data_s_o, data_w_o, data_e_o, data_p_o;
  logic [4:0] data_void_i;
  logic [4:0] data_void_o;
  logic [4:0] stop_i;
  logic [4:0] stop_o;
  integer     seed;

  // Flits to send per input and the expected and taken flits per output
  flit_t tx_q  [NumPorts][$];
  flit_t exp_q [NumPorts][$];
  flit_t got_q [NumPorts][$];

  mesh_router dut_i (
    .clk        (clk),
    .rst        (rst),
    .position_i (position),
    .data_n_i   (data_n_i),
    .data_s_i   (data_s_i),
    .data_w_i   (data_w_i),
    .data_e_i   (data_e_i),
    .data_p_i   (data_p_i),
    .data_void_i(data_void_i),
    .stop_o     (stop_o),
    .data_n_o   (data_n_o),
    .data_s_o   (data_s_o),
    .data_w_o   (data_w_o),
    .data_e_o   (data_e_o),
    .data_p_o   (data_p_o),
    .data_void_o(data_void_o),
    .stop_i     (stop_i)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Flit builders and reference routing
  ////////////////////////////////////////
  function automatic flit_t make_head(xy_t dest, xy_t src, logic [14:0] payload, dir_t route,
                                      logic tail);
    flit_t f;
    f                             = '0;
    f[HeadBit]                    = 1'b1;
    f[TailBit]                    = tail;
    f[DestLsb +: 6]               = dest;
    f[SrcLsb +: 6]                = src;
    f[SrcLsb-1:RouteWidth]        = payload;
    f[RouteLsb +: RouteWidth]     = route;
    return f;
  endfunction

  function automatic flit_t make_body(logic [DataWidth-1:0] payload, logic tail);
    return {1'b0, tail, payload};
  endfunction

  // XY rule seen from router (cx, cy) with x first
  function automatic dir_t xy_choice(int cx, int cy, xy_t dest);
    int dx;
    int dy;
    dx = int'(dest[5:3]);
    dy = int'(dest[2:0]);
    if (dx > cx) return GoEast;
    if (dx < cx) return GoWest;
    if (dy > cy) return GoSouth;
    if (dy < cy) return GoNorth;
    return GoLocal;
  endfunction

  // Direction the neighbor behind out_port will take
  function automatic dir_t next_hop(int out_port, xy_t dest);
    int nx;
    int ny;
    nx = MyX;
    ny = MyY;
    if (out_port == int'(PortLocal)) return GoLocal;
    case (out_port)
      int'(PortNorth): ny = ny - 1;
      int'(PortSouth): ny = ny + 1;
      int'(PortWest):  nx = nx - 1;
      default:         nx = nx + 1;
    endcase
    return xy_choice(nx, ny, dest);
  endfunction

  function automatic int dir_port(dir_t d);
    for (int i = 0; i < NumPorts; i++) begin
      if (d[i]) return i;
    end
    return int'(PortLocal);
  endfunction

  function automatic flit_t out_data(int p);
    case (p)
      0:       return data_n_o;
      1:       return data_s_o;
      2:       return data_w_o;
      3:       return data_e_o;
      default: return data_p_o;
    endcase
  endfunction

  function automatic string out_name(int p);
    case (p)
      0:       return "data_n_o";
      1:       return "data_s_o";
      2:       return "data_w_o";
      3:       return "data_e_o";
      default: return "data_p_o";
    endcase
  endfunction

  // Random destination that leaves through direction d
  function automatic xy_t pick_dest(int d);
    coord_t x;
    coord_t y;
    x = 3'(MyX);
    y = 3'($unsigned($random(seed)) % 8);
    case (d)
      int'(PortNorth): y = 3'($unsigned($random(seed)) % MyY);
      int'(PortSouth): y = 3'(MyY + 1 + $unsigned($random(seed)) % 5);
      int'(PortWest):  x = 3'($unsigned($random(seed)) % MyX);
      int'(PortEast):  x = 3'(MyX + 1 + $unsigned($random(seed)) % 5);
      default:         y = 3'(MyY);
    endcase
    return {x, y};
  endfunction

  ////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////
  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(string name, flit_t got, flit_t exp);
    $display("MISMATCH %s got %h expected %h", name, got, exp);
    fail_run();
  endtask

  task automatic report_fail(string what);
    $display("ERROR %s", what);
    fail_run();
  endtask

  ////////////////////////////////////////
  // Link drivers and output monitor
  ////////////////////////////////////////
  task automatic drive_flit(int p, flit_t f);
    case (p)
      0:       data_n_i = f;
      1:       data_s_i = f;
      2:       data_w_i = f;
      3:       data_e_i = f;
      default: data_p_i = f;
    endcase
    data_void_i[p] = 1'b0;
  endtask

  task automatic drive_idle(int p);
    data_void_i[p] = 1'b1;
  endtask

  // Sends the queued flits of input p but never while stop_o is high
  task automatic send_port(int p);
    int cnt;
    while (tx_q[p].size() > 0) begin
      @(negedge clk);
      cnt = 0;
      while (stop_o[p]) begin
        drive_idle(p);
        cnt++;
        if (cnt > WaitLimit) report_fail("input stayed stopped too long");
        @(negedge clk);
      end
      drive_flit(p, tx_q[p].pop_front());
    end
    @(negedge clk);
    drive_idle(p);
  endtask

  // A flit counts as taken on an edge with void low and stop low
  always @(posedge clk) begin
    if (!rst) begin
      for (int b = 0; b < NumPorts; b++) begin
        if (!data_void_o[b] && !stop_i[b]) begin
          got_q[b].push_back(out_data(b));
        end
      end
    end
  end

  task automatic clear_queues();
    for (int p = 0; p < NumPorts; p++) begin
      tx_q[p].delete();
      exp_q[p].delete();
      got_q[p].delete();
    end
  endtask

  task automatic wait_delivery(int p, int n);
    int cnt;
    cnt = 0;
    while (got_q[p].size() < n) begin
      @(negedge clk);
      cnt++;
      if (cnt > WaitLimit) report_fail({"flits missing on ", out_name(p)});
    end
  endtask

  // Waits for all expected flits and then checks count and order
  task automatic compare_port(int p);
    flit_t got;
    flit_t exp;
    wait_delivery(p, exp_q[p].size());
    repeat (3) @(negedge clk);
    assert (got_q[p].size() == exp_q[p].size())
      else report_mismatch({out_name(p), " count"}, got_q[p].size(), exp_q[p].size());
    while (exp_q[p].size() > 0) begin
      got = got_q[p].pop_front();
      exp = exp_q[p].pop_front();
      assert (got === exp) else report_mismatch(out_name(p), got, exp);
    end
  endtask

  // Queues a worm on src_port and its expected form on the output
  task automatic build_worm(input int src_port, input xy_t dest, input int len,
                            output int out_port);
    dir_t        route;
    flit_t       f;
    logic [14:0] hp;
    route    = xy_choice(MyX, MyY, dest);
    out_port = dir_port(route);
    hp       = 15'($random(seed));
    tx_q[src_port].push_back(make_head(dest, xy_t'(src_port), hp, route, len == 1));
    exp_q[out_port].push_back(make_head(dest, xy_t'(src_port), hp,
                                        next_hop(out_port, dest), len == 1));
    for (int k = 1; k < len; k++) begin
      f = make_body($random(seed), k == len - 1);
      tx_q[src_port].push_back(f);
      exp_q[out_port].push_back(f);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic check_reset_state();
    assert (data_void_o === 5'h1f) else report_mismatch("data_void_o", data_void_o, 5'h1f);
    assert (stop_o === 5'h00) else report_mismatch("stop_o", stop_o, 5'h00);
  endtask

  // Uncontended flit must leave one cycle after it is taken
  task automatic single_flit_east();
    int out;
    clear_queues();
    build_worm(PortLocal, {3'd4, 3'd2}, 1, out);
    @(negedge clk);
    assert (!stop_o[PortLocal]) else report_fail("local input stopped before the flit");
    drive_flit(PortLocal, tx_q[PortLocal].pop_front());
    @(negedge clk);
    drive_idle(PortLocal);
    assert (data_void_o[PortEast] === 1'b0)
      else report_mismatch("data_void_o[3]", data_void_o[PortEast], 1'b0);
    assert (data_e_o === exp_q[PortEast][0])
      else report_mismatch("data_e_o", data_e_o, exp_q[PortEast][0]);
    compare_port(PortEast);
  endtask

  task automatic worm_to_local();
    int out;
    clear_queues();
    build_worm(PortWest, {3'd2, 3'd2}, 4, out);
    send_port(PortWest);
    compare_port(out);
  endtask

  // Two worms race for local and each must come out whole
  task automatic contention_to_local();
    int    out;
    flit_t f;
    clear_queues();
    build_worm(PortNorth, {3'd2, 3'd2}, 4, out);
    build_worm(PortSouth, {3'd2, 3'd2}, 4, out);
    fork
      send_port(PortNorth);
      send_port(PortSouth);
    join
    wait_delivery(PortLocal, 8);
    // South won so its worm leads the expectation
    if (got_q[PortLocal][0] !== exp_q[PortLocal][0]) begin
      for (int k = 0; k < 4; k++) begin
        f = exp_q[PortLocal].pop_front();
        exp_q[PortLocal].push_back(f);
      end
    end
    compare_port(PortLocal);
  endtask

  // Stop on east until the local queue fills while the output stays frozen
  task automatic stop_backpressure();
    int    out;
    int    cnt;
    flit_t held;
    logic  held_void;
    clear_queues();
    @(negedge clk);
    stop_i[PortEast] = 1'b1;
    build_worm(PortLocal, {3'd5, 3'd2}, 6, out);
    @(negedge clk);
    held      = data_e_o;
    held_void = data_void_o[PortEast];
    fork
      send_port(PortLocal);
      begin
        cnt = 0;
        while (!stop_o[PortLocal]) begin
          @(negedge clk);
          assert (data_e_o === held) else report_mismatch("data_e_o", data_e_o, held);
          assert (data_void_o[PortEast] === held_void)
            else report_mismatch("data_void_o[3]", data_void_o[PortEast], held_void);
          cnt++;
          if (cnt > WaitLimit) report_fail("stop_o of the local input never rose");
        end
        stop_i[PortEast] = 1'b0;
      end
    join
    compare_port(out);
  endtask

  task automatic random_worms();
    int  out;
    int  len;
    xy_t dest;
    for (int p = 0; p < NumPorts; p++) begin
      for (int d = 0; d < NumPorts; d++) begin
        dest = pick_dest(d);
        // No U-turn onto the input's own link
        if (dir_port(xy_choice(MyX, MyY, dest)) != p) begin
          clear_queues();
          len = 1 + int'($unsigned($random(seed)) % 4);
          build_worm(p, dest, len, out);
          send_port(p);
          compare_port(out);
        end
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    position    = {3'(MyX), 3'(MyY)};
    data_n_i    = '0;
    data_s_i    = '0;
    data_w_i    = '0;
    data_e_i    = '0;
    data_p_i    = '0;
    data_void_i = '1;
    stop_i      = '0;
    seed        = 32'hd3709962;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    single_flit_east();
    worm_to_local();
    contention_to_local();
    stop_backpressure();
    random_worms();
    if (dut_i.u_props.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: mesh_router.f
rtl/noc_router_pkg.sv
rtl/router_input_queue.sv
rtl/router_rr_arbiter.sv
rtl/lookahead_xy_route.sv
rtl/router_output_port.sv
rtl/mesh_router.sv
dv/mesh_router_properties.sv
dv/mesh_router_tb.sv
